// File: compile.f
verilog/execPkg.sv
verilog/issueBuffer.sv
verilog/regFile.sv
verilog/alu.sv
verilog/multDiv.sv
verilog/execStage.sv
verilog/execCore.sv
testbench/tbExecCore.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f compile.f --top-module tbExecCore -o simExecCore
./obj_dir/simExecCore

// File: testbench/execGolden.txt
# I pc op rs rt rd useImm imm shamt  (one issueOp_t, all hex)
# R pc wen wnum wdata  (expected retire_t in retire order, all hex)
I 00400000 00 00 00 01 1 00000007 00
R 00400000 1 01 00000007
I 00400004 00 00 00 02 1 fffffffd 00
R 00400004 1 02 fffffffd
I 00400008 01 01 02 03 0 00000000 00
R 00400008 1 03 0000000a
I 0040000c 04 03 02 04 0 00000000 00
R 0040000c 1 04 fffffff7
I 00400010 05 04 01 05 0 00000000 00
R 00400010 1 05 00000008
I 00400014 03 05 00 06 1 00000f00 00
R 00400014 1 06 00000f08
I 00400018 02 06 04 07 0 00000000 00
R 00400018 1 07 00000f00
I 0040001c 06 02 01 08 0 00000000 00
R 0040001c 1 08 00000001
I 00400020 07 02 01 09 0 00000000 00
R 00400020 1 09 00000000
I 00400024 0b 00 00 0a 1 00008001 00
R 00400024 1 0a 80010000
I 00400028 0a 00 0a 0b 0 00000000 04
R 00400028 1 0b f8001000
I 0040002c 09 00 0a 0c 0 00000000 08
R 0040002c 1 0c 00800100
I 00400030 08 00 01 0d 0 00000000 1c
R 00400030 1 0d 70000000
I 00400034 00 01 01 00 0 00000000 00
R 00400034 1 00 0000000e
I 00400038 00 00 00 0e 0 00000000 00
R 00400038 1 0e 00000000
I 0040003c 0c 02 0a 00 0 00000000 00
R 0040003c 0 00 00000000
I 00400040 10 00 00 0f 0 00000000 00
R 00400040 1 0f 00000001
I 00400044 11 00 00 10 0 00000000 00
R 00400044 1 10 7ffd0000
I 00400048 0d 02 01 00 0 00000000 00
R 00400048 0 00 00000000
I 0040004c 10 00 00 11 0 00000000 00
R 0040004c 1 11 00000006
I 00400050 0e 04 01 00 0 00000000 00
R 00400050 0 00 00000000
I 00400054 11 00 00 12 0 00000000 00
R 00400054 1 12 ffffffff
I 00400058 10 00 00 13 0 00000000 00
R 00400058 1 13 fffffffe
I 0040005c 0f 06 00 00 0 00000000 00
R 0040005c 0 00 00000000
I 00400060 11 00 00 14 0 00000000 00
R 00400060 1 14 ffffffff
I 00400064 10 00 00 15 0 00000000 00
R 00400064 1 15 00000f08
I 00400068 12 0c 00 00 0 00000000 00
R 00400068 0 00 00800100
I 0040006c 13 0b 00 00 0 00000000 00
R 0040006c 0 00 f8001000
I 00400070 10 00 00 16 0 00000000 00
R 00400070 1 16 00800100
I 00400074 11 00 00 17 0 00000000 00
R 00400074 1 17 f8001000

// File: testbench/tbExecCore.sv
`timescale 1ns/1ps

module tbExecCore;

    logic              aclk;
    logic              reset_i;
    logic              issueValid_i;
    execPkg::issueOp_t issueOp_i;
    logic              creditReturn_o;
    logic              retireValid_o;
    execPkg::retire_t  retire_o;

    execPkg::issueOp_t stimQ [$];
    execPkg::retire_t  expQ [$];
    execPkg::retire_t  expRec;
    logic [31:0]       rngState;
    int                issuedCnt;    // written by the driver only
    int                returnedCnt;  // written by the monitor only
    int                retired;
    int                nExpected;
    logic              loaded;

    execCore dut0 (
        .aclk           (aclk),
        .reset_i        (reset_i),
        .issueValid_i   (issueValid_i),
        .issueOp_i      (issueOp_i),
        .creditReturn_o (creditReturn_o),
        .retireValid_o  (retireValid_o),
        .retire_o       (retire_o)
    );

    initial begin
        aclk = 1'b0;
    end

    always #10 aclk = ~aclk;  // 20 ns period

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1);
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // credits the sender holds right now
    function automatic int creditsHeld();
        return execPkg::ISSUE_CREDITS - issuedCnt + returnedCnt;
    endfunction

    task automatic checkRetire(input execPkg::retire_t exp, input execPkg::retire_t act,
                               input int idx);
        if (act.pc !== exp.pc) begin
            abortRun($sformatf("Fail retire_o.pc record %0d: expected %h, got %h",
                               idx, exp.pc, act.pc));
        end else if (act.wen !== exp.wen) begin
            abortRun($sformatf("Fail retire_o.wen record %0d: expected %h, got %h",
                               idx, exp.wen, act.wen));
        end else if (act.wnum !== exp.wnum) begin
            abortRun($sformatf("Fail retire_o.wnum record %0d: expected %h, got %h",
                               idx, exp.wnum, act.wnum));
        end else if (act.wdata !== exp.wdata) begin
            abortRun($sformatf("Fail retire_o.wdata record %0d: expected %h, got %h",
                               idx, exp.wdata, act.wdata));
        end
    endtask

    // I lines become issue ops and R lines expected retire records
    task automatic loadGolden();
        int                fd;
        int                n;
        string             line;
        string             rest;
        logic [31:0]       col0, col1, col2, col3, col4, col5, col6, col7;
        execPkg::issueOp_t op;
        execPkg::retire_t  rec;
        fd = $fopen("testbench/execGolden.txt", "r");
        if (fd == 0) begin
            abortRun("could not open testbench/execGolden.txt");
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 1 && (line.substr(0, 0) == "I" || line.substr(0, 0) == "R")) begin
                rest = line.substr(1, line.len() - 1);
                if (line.substr(0, 0) == "I") begin
                    n = $sscanf(rest, "%h %h %h %h %h %h %h %h",
                                col0, col1, col2, col3, col4, col5, col6, col7);
                    if (n != 8) begin
                        abortRun("malformed I line in the golden file");
                    end
                    op.pc     = col0;
                    op.op     = execPkg::opcode_t'(col1[4:0]);
                    op.rs     = col2[4:0];
                    op.rt     = col3[4:0];
                    op.rd     = col4[4:0];
                    op.useImm = col5[0];
                    op.imm    = col6;
                    op.shamt  = col7[4:0];
                    stimQ.push_back(op);
                end else begin
                    n = $sscanf(rest, "%h %h %h %h", col0, col1, col2, col3);
                    if (n != 4) begin
                        abortRun("malformed R line in the golden file");
                    end
                    rec.pc    = col0;
                    rec.wen   = col1[0];
                    rec.wnum  = col2[4:0];
                    rec.wdata = col3;
                    expQ.push_back(rec);
                end
            end
        end
        $fclose(fd);
    endtask

    // random idle cycles between issues within the credits held
    task automatic issueAll();
        int idx;
        idx = 0;
        while (idx < stimQ.size()) begin
            @(posedge aclk);
            rngState = xorshift32(rngState);
            if (creditsHeld() > 0 && rngState[1:0] != 2'b00) begin
                issueValid_i <= 1'b1;
                issueOp_i    <= stimQ[idx];
                idx++;
                issuedCnt++;
            end else begin
                issueValid_i <= 1'b0;
            end
        end
        @(posedge aclk);
        issueValid_i <= 1'b0;
    endtask

    // sampled mid-cycle where outputs are settled
    always @(negedge aclk) begin
        if (!reset_i) begin
            if (retireValid_o) begin
                if (expQ.size() == 0) begin
                    abortRun("a record retired with no instruction left to retire");
                end else begin
                    expRec = expQ.pop_front();
                    checkRetire(expRec, retire_o, retired);
                    retired++;
                end
            end
            if (creditReturn_o) begin
                returnedCnt++;
            end
            if (creditsHeld() > execPkg::ISSUE_CREDITS) begin
                abortRun("sender credits rose above the issue buffer depth");
            end
        end
    end

    initial begin
        wait (loaded);
        repeat (stimQ.size() * (execPkg::MULDIV_STEPS + 8) + 100) @(posedge aclk);
        abortRun("watchdog expired before the retire trace completed");
    end

    initial begin
        reset_i      = 1'b1;
        issueValid_i = 1'b0;
        issueOp_i    = '0;
        rngState     = 32'hbde7f4d0;
        issuedCnt    = 0;
        returnedCnt  = 0;
        retired      = 0;
        loaded       = 1'b0;
        loadGolden();
        nExpected = expQ.size();
        if (stimQ.size() == 0 || stimQ.size() != nExpected) begin
            abortRun("golden file needs one R line per I line");
        end
        loaded = 1'b1;
        repeat (5) @(posedge aclk);
        reset_i <= 1'b0;
        issueAll();
        while (retired < nExpected) begin
            @(posedge aclk);
        end
        repeat (10) @(posedge aclk);  // room for a stray extra retire
        if (creditsHeld() != execPkg::ISSUE_CREDITS) begin
            abortRun("not all credits came back after the last retire");
        end else begin
            $display("Regression passed");
            $finish;
        end
    end

endmodule

// File: verilog/alu.sv
`timescale 1ns/1ps

module alu (
    input  execPkg::opcode_t                op_i,
    input  logic [execPkg::DATA_W-1:0]      a_i,
    input  logic [execPkg::DATA_W-1:0]      b_i,
    input  logic [execPkg::REG_ADDR_W-1:0]  shamt_i,
    output logic [execPkg::DATA_W-1:0]      result_o
);

    logic ltSigned;
    logic ltUnsigned;

    assign ltSigned   = $signed(a_i) < $signed(b_i);
    assign ltUnsigned = a_i < b_i;

    // shifts work on operand b (rt) by the shamt field
    always_comb begin
        case (op_i)
            execPkg::opAdd:  result_o = a_i + b_i;
            execPkg::opSub:  result_o = a_i - b_i;
            execPkg::opAnd:  result_o = a_i & b_i;
            execPkg::opOr:   result_o = a_i | b_i;
            execPkg::opXor:  result_o = a_i ^ b_i;
            execPkg::opNor:  result_o = ~(a_i | b_i);
            execPkg::opSlt:  result_o = {{(execPkg::DATA_W - 1){1'b0}}, ltSigned};
            execPkg::opSltu: result_o = {{(execPkg::DATA_W - 1){1'b0}}, ltUnsigned};
            execPkg::opSll:  result_o = b_i << shamt_i;
            execPkg::opSrl:  result_o = b_i >> shamt_i;
            execPkg::opSra:  result_o = $signed(b_i) >>> shamt_i;
            execPkg::opLui:  result_o = b_i << 16;  // imm into the upper half
            default:         result_o = '0;         // hi/lo ops, handled outside
        endcase
    end

endmodule

// File: verilog/execCore.sv
`timescale 1ns/1ps

module execCore (
    input  logic              aclk,
    input  logic              reset_i,
    input  logic              issueValid_i,
    input  execPkg::issueOp_t issueOp_i,
    output logic              creditReturn_o,
    output logic              retireValid_o,
    output execPkg::retire_t  retire_o
);

    logic                           headValid;
    execPkg::issueOp_t              headOp;
    logic                           advance;
    logic [execPkg::DATA_W-1:0]     rdataA;
    logic [execPkg::DATA_W-1:0]     rdataB;
    logic                           rfWe;
    logic [execPkg::REG_ADDR_W-1:0] rfWaddr;
    logic [execPkg::DATA_W-1:0]     rfWdata;

    issueBuffer issueBuffer0 (
        .aclk           (aclk),
        .reset_i        (reset_i),
        .pushValid_i    (issueValid_i),
        .pushOp_i       (issueOp_i),
        .pop_i          (advance),
        .headValid_o    (headValid),
        .headOp_o       (headOp),
        .creditReturn_o (creditReturn_o)
    );

    // operands are read straight from the buffer head
    regFile regFile0 (
        .aclk     (aclk),
        .reset_i  (reset_i),
        .raddrA_i (headOp.rs),
        .raddrB_i (headOp.rt),
        .rdataA_o (rdataA),
        .rdataB_o (rdataB),
        .we_i     (rfWe),
        .waddr_i  (rfWaddr),
        .wdata_i  (rfWdata)
    );

    execStage execStage0 (
        .aclk          (aclk),
        .reset_i       (reset_i),
        .headValid_i   (headValid),
        .headOp_i      (headOp),
        .rdataA_i      (rdataA),
        .rdataB_i      (rdataB),
        .advance_o     (advance),
        .rfWe_o        (rfWe),
        .rfWaddr_o     (rfWaddr),
        .rfWdata_o     (rfWdata),
        .retireValid_o (retireValid_o),
        .retire_o      (retire_o)
    );

endmodule

// File: verilog/execPkg.sv
package execPkg;

    localparam int DATA_W        = 32;
    localparam int REG_ADDR_W    = 5;
    localparam int ISSUE_CREDITS = 4;   // buffer depth, also the sender's starting credits
    localparam int MULDIV_STEPS  = 32;  // one product or quotient bit per step

    // derived widths for the counters and pointers
    localparam int ISSUE_PTR_W  = $clog2(ISSUE_CREDITS);
    localparam int ISSUE_CNT_W  = $clog2(ISSUE_CREDITS + 1);
    localparam int MULDIV_CNT_W = $clog2(MULDIV_STEPS + 1);

    typedef enum logic [4:0] {
        opAdd,
        opSub,
        opAnd,
        opOr,
        opXor,
        opNor,
        opSlt,
        opSltu,
        opSll,
        opSrl,
        opSra,
        opLui,
        opMult,
        opMultu,
        opDiv,
        opDivu,
        opMfhi,
        opMflo,
        opMthi,
        opMtlo
    } opcode_t;

    typedef enum logic [1:0] {
        mdMult,
        mdMultu,
        mdDiv,
        mdDivu
    } muldivOp_t;

    // one decoded instruction, 90 bits
    typedef struct packed {
        logic [DATA_W-1:0]     pc;
        opcode_t               op;
        logic [REG_ADDR_W-1:0] rs;
        logic [REG_ADDR_W-1:0] rt;
        logic [REG_ADDR_W-1:0] rd;
        logic                  useImm;  // imm replaces rt as operand b
        logic [DATA_W-1:0]     imm;     // already sign or zero extended
        logic [REG_ADDR_W-1:0] shamt;
    } issueOp_t;

    // retire record, 70 bits
    typedef struct packed {
        logic [DATA_W-1:0]     pc;
        logic                  wen;
        logic [REG_ADDR_W-1:0] wnum;
        logic [DATA_W-1:0]     wdata;
    } retire_t;

endpackage

// File: verilog/execStage.sv
`timescale 1ns/1ps

module execStage (
    input  logic                           aclk,
    input  logic                           reset_i,
    input  logic                           headValid_i,
    input  execPkg::issueOp_t              headOp_i,
    input  logic [execPkg::DATA_W-1:0]     rdataA_i,
    input  logic [execPkg::DATA_W-1:0]     rdataB_i,
    output logic                           advance_o,
    output logic                           rfWe_o,
    output logic [execPkg::REG_ADDR_W-1:0] rfWaddr_o,
    output logic [execPkg::DATA_W-1:0]     rfWdata_o,
    output logic                           retireValid_o,
    output execPkg::retire_t               retire_o
);

    // read-to-execute register
    logic                       exValid;
    execPkg::issueOp_t          exOp;
    logic [execPkg::DATA_W-1:0] exA;
    logic [execPkg::DATA_W-1:0] exB;

    // execute-to-write-back register
    logic                       wbValid;
    execPkg::retire_t           wbRec;

    logic                       stall;
    logic                       exFire;
    logic                       fwdHitA;
    logic                       fwdHitB;
    logic [execPkg::DATA_W-1:0] opA;
    logic [execPkg::DATA_W-1:0] opB;
    logic [execPkg::DATA_W-1:0] aluB;
    logic [execPkg::DATA_W-1:0] aluResult;
    logic                       isMulDiv;
    logic                       writesRd;
    execPkg::muldivOp_t         mdCmd;
    logic                       mdBusy;
    logic [execPkg::DATA_W-1:0] mdHi;
    logic [execPkg::DATA_W-1:0] mdLo;
    execPkg::retire_t           exRec;

    // in-order retire, so nothing passes a running mult/div
    assign stall     = mdBusy;
    assign exFire    = exValid && !stall;
    assign advance_o = headValid_i && !stall;

    // write-back bypass, $zero excluded
    assign fwdHitA = wbValid && wbRec.wen && (wbRec.wnum != '0) && (wbRec.wnum == exOp.rs);
    assign fwdHitB = wbValid && wbRec.wen && (wbRec.wnum != '0) && (wbRec.wnum == exOp.rt);
    assign opA     = fwdHitA ? wbRec.wdata : exA;
    assign opB     = fwdHitB ? wbRec.wdata : exB;
    assign aluB    = exOp.useImm ? exOp.imm : opB;

    always_comb begin
        isMulDiv = 1'b0;
        writesRd = 1'b1;
        case (exOp.op)
            execPkg::opMult, execPkg::opMultu,
            execPkg::opDiv, execPkg::opDivu: begin
                isMulDiv = 1'b1;
                writesRd = 1'b0;
            end
            execPkg::opMthi, execPkg::opMtlo: begin
                writesRd = 1'b0;
            end
            default: begin
                writesRd = 1'b1;
            end
        endcase
    end

    always_comb begin
        case (exOp.op)
            execPkg::opMultu: mdCmd = execPkg::mdMultu;
            execPkg::opDiv:   mdCmd = execPkg::mdDiv;
            execPkg::opDivu:  mdCmd = execPkg::mdDivu;
            default:          mdCmd = execPkg::mdMult;
        endcase
    end

    alu alu0 (
        .op_i     (exOp.op),
        .a_i      (opA),
        .b_i      (aluB),
        .shamt_i  (exOp.shamt),
        .result_o (aluResult)
    );

    multDiv multDiv0 (
        .aclk    (aclk),
        .reset_i (reset_i),
        .start_i (exFire && isMulDiv),
        .cmd_i   (mdCmd),
        .a_i     (opA),
        .b_i     (opB),
        .hiWe_i  (exFire && (exOp.op == execPkg::opMthi)),
        .loWe_i  (exFire && (exOp.op == execPkg::opMtlo)),
        .wdata_i (opA),
        .busy_o  (mdBusy),
        .hi_o    (mdHi),
        .lo_o    (mdLo)
    );

    always_comb begin
        exRec.pc   = exOp.pc;
        exRec.wen  = writesRd;
        exRec.wnum = exOp.rd;
        case (exOp.op)
            execPkg::opMfhi:                  exRec.wdata = mdHi;
            execPkg::opMflo:                  exRec.wdata = mdLo;
            execPkg::opMthi, execPkg::opMtlo: exRec.wdata = opA;  // value sent to hi/lo
            default:                          exRec.wdata = aluResult;
        endcase
    end

    always_ff @(posedge aclk) begin
        if (reset_i) begin
            exValid <= 1'b0;
            wbValid <= 1'b0;
        end else begin
            if (!stall) begin
                exValid <= headValid_i;
            end
            wbValid <= exFire;  // bubble into wb while stalled
        end
    end

    always_ff @(posedge aclk) begin
        if (!stall) begin
            exOp <= headOp_i;
            exA  <= rdataA_i;
            exB  <= rdataB_i;
        end else begin
            // keep the bypassed value, wb drains during the stall
            exA <= opA;
            exB <= opB;
        end
        wbRec <= exRec;
    end

    assign rfWe_o        = wbValid && wbRec.wen;
    assign rfWaddr_o     = wbRec.wnum;
    assign rfWdata_o     = wbRec.wdata;
    assign retireValid_o = wbValid;
    assign retire_o      = wbRec;

endmodule

// File: verilog/issueBuffer.sv
`timescale 1ns/1ps

module issueBuffer (
    input  logic              aclk,
    input  logic              reset_i,
    input  logic              pushValid_i,
    input  execPkg::issueOp_t pushOp_i,
    input  logic              pop_i,
    output logic              headValid_o,
    output execPkg::issueOp_t headOp_o,
    output logic              creditReturn_o
);

    execPkg::issueOp_t                mem [execPkg::ISSUE_CREDITS];
    logic [execPkg::ISSUE_PTR_W-1:0] rdPtr;
    logic [execPkg::ISSUE_PTR_W-1:0] wrPtr;
    logic [execPkg::ISSUE_CNT_W-1:0] count;
    logic                            doPop;

    assign headValid_o    = (count != '0);
    assign headOp_o       = mem[rdPtr];
    assign doPop          = pop_i && headValid_o;
    assign creditReturn_o = doPop;  // one credit back per dequeue

    // sender never pushes without a credit, so no full check here
    always_ff @(posedge aclk) begin
        if (pushValid_i) begin
            mem[wrPtr] <= pushOp_i;
        end
    end

    always_ff @(posedge aclk) begin
        if (reset_i) begin
            rdPtr <= '0;
            wrPtr <= '0;
            count <= '0;
        end else begin
            if (pushValid_i) begin
                wrPtr <= (wrPtr == execPkg::ISSUE_PTR_W'(execPkg::ISSUE_CREDITS - 1)) ?
                         '0 : wrPtr + 1'b1;
            end
            if (doPop) begin
                rdPtr <= (rdPtr == execPkg::ISSUE_PTR_W'(execPkg::ISSUE_CREDITS - 1)) ?
                         '0 : rdPtr + 1'b1;
            end
            case ({pushValid_i, doPop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // both or neither
            endcase
        end
    end

endmodule

// File: verilog/multDiv.sv
`timescale 1ns/1ps

module multDiv (
    input  logic                       aclk,
    input  logic                       reset_i,
    input  logic                       start_i,
    input  execPkg::muldivOp_t         cmd_i,
    input  logic [execPkg::DATA_W-1:0] a_i,
    input  logic [execPkg::DATA_W-1:0] b_i,
    input  logic                       hiWe_i,
    input  logic                       loWe_i,
    input  logic [execPkg::DATA_W-1:0] wdata_i,
    output logic                       busy_o,
    output logic [execPkg::DATA_W-1:0] hi_o,
    output logic [execPkg::DATA_W-1:0] lo_o
);

    localparam int W = execPkg::DATA_W;

    logic [execPkg::MULDIV_CNT_W-1:0] stepCnt;
    logic                             lastStep;
    logic                             isDiv;
    logic                             negMain;  // sign fix for product or quotient
    logic                             negRem;   // remainder follows the dividend
    logic [W-1:0]                     operand;  // multiplicand or divisor
    logic [2*W-1:0]                   acc;      // product, or {remainder, quotient}

    logic         startSigned;
    logic         startDiv;
    logic [W-1:0] magA;
    logic [W-1:0] magB;
    logic [W:0]   mulSum;
    logic [W:0]   divShift;
    logic [W:0]   divDiff;
    logic         divFits;
    logic [W-1:0] divRem;
    logic [2*W-1:0] prodFinal;
    logic [W-1:0] quoFinal;
    logic [W-1:0] remFinal;

    assign startSigned = (cmd_i == execPkg::mdMult) || (cmd_i == execPkg::mdDiv);
    assign startDiv    = (cmd_i == execPkg::mdDiv) || (cmd_i == execPkg::mdDivu);
    assign magA        = (startSigned && a_i[W-1]) ? -a_i : a_i;
    assign magB        = (startSigned && b_i[W-1]) ? -b_i : b_i;

    assign lastStep = (stepCnt == execPkg::MULDIV_CNT_W'(execPkg::MULDIV_STEPS));

    // shift-add, multiplier bits drop out of the low half
    assign mulSum = {1'b0, acc[2*W-1:W]} + (acc[0] ? {1'b0, operand} : '0);

    // restoring step, dividend bits shift up out of the quotient half
    assign divShift = {acc[2*W-1:W], acc[W-1]};
    assign divDiff  = divShift - {1'b0, operand};
    assign divFits  = (divShift >= {1'b0, operand});
    assign divRem   = divFits ? divDiff[W-1:0] : divShift[W-1:0];

    // a zero divisor always fits: quotient all ones, remainder the dividend
    assign prodFinal = negMain ? -acc : acc;
    assign quoFinal  = negMain ? -acc[W-1:0] : acc[W-1:0];
    assign remFinal  = negRem ? -acc[2*W-1:W] : acc[2*W-1:W];

    always_ff @(posedge aclk) begin
        if (reset_i) begin
            busy_o  <= 1'b0;
            stepCnt <= '0;
            hi_o    <= '0;
            lo_o    <= '0;
        end else if (busy_o) begin
            if (lastStep) begin
                busy_o <= 1'b0;
                if (isDiv) begin
                    hi_o <= remFinal;
                    lo_o <= quoFinal;
                end else begin
                    hi_o <= prodFinal[2*W-1:W];
                    lo_o <= prodFinal[W-1:0];
                end
            end else begin
                stepCnt <= stepCnt + 1'b1;
            end
        end else begin
            if (start_i) begin
                busy_o  <= 1'b1;
                stepCnt <= '0;
            end
            if (hiWe_i) begin
                hi_o <= wdata_i;  // mthi
            end
            if (loWe_i) begin
                lo_o <= wdata_i;  // mtlo
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (start_i && !busy_o) begin
            isDiv   <= startDiv;
            negMain <= startSigned && (a_i[W-1] ^ b_i[W-1]);
            negRem  <= startSigned && a_i[W-1];
            operand <= startDiv ? magB : magA;
            acc     <= {{W{1'b0}}, startDiv ? magA : magB};
        end else if (busy_o && !lastStep) begin
            acc <= isDiv ? {divRem, acc[W-2:0], divFits} : {mulSum, acc[W-1:1]};
        end
    end

endmodule

// File: verilog/regFile.sv
`timescale 1ns/1ps

module regFile (
    input  logic                           aclk,
    input  logic                           reset_i,
    input  logic [execPkg::REG_ADDR_W-1:0] raddrA_i,
    input  logic [execPkg::REG_ADDR_W-1:0] raddrB_i,
    output logic [execPkg::DATA_W-1:0]     rdataA_o,
    output logic [execPkg::DATA_W-1:0]     rdataB_o,
    input  logic                           we_i,
    input  logic [execPkg::REG_ADDR_W-1:0] waddr_i,
    input  logic [execPkg::DATA_W-1:0]     wdata_i
);

    logic [execPkg::DATA_W-1:0] regs [2**execPkg::REG_ADDR_W];
    logic                       hitA;
    logic                       hitB;

    // $zero never takes a write, so it stays at its reset value
    always_ff @(posedge aclk) begin
        if (reset_i) begin
            for (int i = 0; i < 2**execPkg::REG_ADDR_W; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // write-through for a read of the register being written
    assign hitA = we_i && (waddr_i != '0) && (waddr_i == raddrA_i);
    assign hitB = we_i && (waddr_i != '0) && (waddr_i == raddrB_i);

    assign rdataA_o = hitA ? wdata_i : regs[raddrA_i];
    assign rdataB_o = hitB ? wdata_i : regs[raddrB_i];

endmodule
